/* hw/lane_fifo.sv */
`timescale 1ns/1ps
`include "wfd_cfg.svh"

module lane_fifo import wfd_pkg::*; (
	input  logic                   CLK125,
	input  logic                   arst_n_i,
	input  logic                   enable_i,
	input  lane_rx_t               rx_i,
	input  logic                   pop_i,
	input  logic                   ovf_clr_i,
	output logic [`WFD_LANE_W-1:0] head_o,
	output lane_stat_t             stat_o,
	output logic                   drop_o
);

	localparam int AW = `WFD_FIFO_AW;
	localparam int CNT_W = `WFD_CNT_W;
	localparam logic [AW:0] DEPTH = 1 << AW;

	logic [`WFD_LANE_W-1:0] mem [0:DEPTH-1];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] occ;
	logic ovf;

	logic accept;
	logic full;
	logic do_wr;
	logic do_rd;

	// Only enabled lanes take data words and K-characters are skipped
	assign accept = enable_i && !rx_i.kchar;
	assign full = (occ == DEPTH);
	assign do_rd = pop_i;

	// A pop in the same cycle frees the slot for the incoming word
	assign do_wr = accept && (!full || do_rd);
	assign drop_o = accept && full && !do_rd;

	////////////////////
	// Storage

	always_ff @(posedge CLK125) begin
		if (do_wr) begin
			mem[wr_ptr] <= rx_i.data;
		end
	end

	// Show-ahead head word
	assign head_o = mem[rd_ptr];

	////////////////////
	// Pointers, occupancy and overflow

	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ <= '0;
			ovf <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: occ <= occ + 1'b1;
				2'b01: occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
			// New drop wins over a clear in the same cycle
			if (drop_o) begin
				ovf <= 1'b1;
			end else if (ovf_clr_i) begin
				ovf <= 1'b0;
			end
		end
	end

	assign stat_o.overflow = ovf;
	assign stat_o.count = CNT_W'(occ);

endmodule

/* hw/led_stretch.sv */
`timescale 1ns/1ps
`include "wfd_cfg.svh"

module led_stretch (
	input  logic CLK125,
	input  logic arst_n_i,
	input  logic trig_i,
	output logic led_o
);

	localparam int HOLD = `WFD_LED_HOLD;
	localparam int CW = $clog2(HOLD + 1);

	logic [CW-1:0] hold_cnt;

	// Each trigger restarts the full on-time
	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hold_cnt <= '0;
		end else if (trig_i) begin
			hold_cnt <= CW'(HOLD);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// Lit while time remains
	assign led_o = (hold_cnt != '0);

endmodule

/* hw/reg_slave.sv */
`timescale 1ns/1ps
`include "wfd_cfg.svh"

module reg_slave import wfd_pkg::*; (
	input  logic                                  CLK125,
	input  logic                                  arst_n_i,
	input  logic                                  req_i,
	input  reg_req_t                              bus_req_i,
	output logic                                  ack_o,
	output logic [`WFD_DATA_W-1:0]                rdata_o,
	input  lane_stat_t [`WFD_LANES-1:0]           lane_stat_i,
	input  logic [`WFD_LANES-1:0][`WFD_LANE_W-1:0] lane_head_i,
	output logic [`WFD_LANES-1:0]                 lane_en_o,
	output logic [`WFD_LANES-1:0]                 pop_o,
	output logic [`WFD_LANES-1:0]                 ovf_clr_o,
	output logic                                  peer_rst_o
);

	localparam int LANE_IW = $clog2(`WFD_LANES);

	hs_state_e state;
	logic req_q;
	logic [`WFD_DATA_W-1:0] csr;

	reg_sel_e sel;
	logic [LANE_IW-1:0] lane_idx;
	logic [`WFD_ADDR_W-1:0] addr_off;
	logic [`WFD_DATA_W-1:0] rd_val;
	logic lane_empty;
	logic access;

	////////////////////
	// Address decode

	always_comb begin
		sel = SEL_NONE;
		addr_off = '0;
		if (bus_req_i.addr == `WFD_REG_VERSION) begin
			sel = SEL_VERSION;
		end else if (bus_req_i.addr == `WFD_REG_CSR) begin
			sel = SEL_CSR;
		end else if (bus_req_i.addr >= `WFD_REG_STAT0 && bus_req_i.addr < `WFD_REG_DATA0) begin
			sel = SEL_STAT;
			addr_off = bus_req_i.addr - `WFD_REG_STAT0;
		end else if (bus_req_i.addr >= `WFD_REG_DATA0 && bus_req_i.addr <= `WFD_REG_LAST) begin
			sel = SEL_DATA;
			addr_off = bus_req_i.addr - `WFD_REG_DATA0;
		end
	end

	assign lane_idx = addr_off[LANE_IW-1:0];
	assign lane_empty = (lane_stat_i[lane_idx].count == '0);
	assign access = (state == HS_ACCESS);

	// Read data, empty lanes return zero
	always_comb begin
		rd_val = '0;
		case (sel)
			SEL_VERSION: rd_val = `WFD_VERSION;
			SEL_CSR: rd_val = csr;
			SEL_STAT: begin
				rd_val[`WFD_STAT_OVF_BIT] = lane_stat_i[lane_idx].overflow;
				rd_val[`WFD_CNT_W-1:0] = lane_stat_i[lane_idx].count;
			end
			SEL_DATA: begin
				if (!lane_empty) begin
					rd_val[`WFD_LANE_W-1:0] = lane_head_i[lane_idx];
				end
			end
			default: rd_val = '0;
		endcase
	end

	// One-cycle strobes, taken at the acknowledging edge
	always_comb begin
		pop_o = '0;
		ovf_clr_o = '0;
		if (access && sel == SEL_DATA && !bus_req_i.we && !lane_empty) begin
			pop_o[lane_idx] = 1'b1;
		end
		if (access && sel == SEL_STAT && bus_req_i.we) begin
			ovf_clr_o[lane_idx] = 1'b1;
		end
	end

	////////////////////
	// Handshake FSM and control register

	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			req_q <= 1'b0;
			state <= HS_IDLE;
			csr <= '0;
		end else begin
			req_q <= req_i;
			case (state)
				HS_IDLE: begin
					if (req_q) begin
						state <= HS_ACCESS;
					end
				end
				HS_ACCESS: begin
					state <= HS_ACK;
					if (bus_req_i.we && sel == SEL_CSR) begin
						csr <= bus_req_i.wdata;
					end
				end
				HS_ACK: begin
					if (!req_q) begin
						state <= HS_IDLE;
					end
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	// Read data held while ack is up
	always_ff @(posedge CLK125) begin
		if (access) begin
			rdata_o <= rd_val;
		end
	end

	assign ack_o = (state == HS_ACK);
	assign lane_en_o = csr[`WFD_LANES-1:0];
	assign peer_rst_o = csr[`WFD_CSR_PEER_BIT];

endmodule

/* hw/wfd_main.sv */
`timescale 1ns/1ps
`include "wfd_cfg.svh"

module wfd_main import wfd_pkg::*; (
	input  logic                       CLK125,
	input  logic                       arst_n_i,
	input  lane_rx_t [`WFD_LANES-1:0]  lane_rx_i,
	input  logic                       req_i,
	input  reg_req_t                   bus_req_i,
	output logic                       ack_o,
	output logic [`WFD_DATA_W-1:0]     rdata_o,
	output logic [`WFD_LANES-1:0]      led_o,
	output logic                       peer_rst_o
);

	lane_stat_t [`WFD_LANES-1:0] lane_stat;
	logic [`WFD_LANES-1:0][`WFD_LANE_W-1:0] lane_head;
	logic [`WFD_LANES-1:0] lane_en;
	logic [`WFD_LANES-1:0] pop;
	logic [`WFD_LANES-1:0] ovf_clr;
	logic [`WFD_LANES-1:0] drop;

	////////////////////
	// Lane FIFOs and front-panel LEDs

	for (genvar i = 0; i < `WFD_LANES; i++) begin : g_lane
		lane_fifo i_lane_fifo (
			.CLK125    (CLK125),
			.arst_n_i  (arst_n_i),
			.enable_i  (lane_en[i]),
			.rx_i      (lane_rx_i[i]),
			.pop_i     (pop[i]),
			.ovf_clr_i (ovf_clr[i]),
			.head_o    (lane_head[i]),
			.stat_o    (lane_stat[i]),
			.drop_o    (drop[i])
		);

		// Overflow indicator
		led_stretch i_led_stretch (
			.CLK125   (CLK125),
			.arst_n_i (arst_n_i),
			.trig_i   (drop[i]),
			.led_o    (led_o[i])
		);
	end

	////////////////////
	// Host register port

	reg_slave i_reg_slave (
		.CLK125      (CLK125),
		.arst_n_i    (arst_n_i),
		.req_i       (req_i),
		.bus_req_i   (bus_req_i),
		.ack_o       (ack_o),
		.rdata_o     (rdata_o),
		.lane_stat_i (lane_stat),
		.lane_head_i (lane_head),
		.lane_en_o   (lane_en),
		.pop_o       (pop),
		.ovf_clr_o   (ovf_clr),
		.peer_rst_o  (peer_rst_o)
	);

endmodule

/* hw/wfd_pkg.sv */
`include "wfd_cfg.svh"

package wfd_pkg;

	////////////////////
	// Lane side

	// One word from a serial-link lane per clock
	typedef struct packed {
		logic [`WFD_LANE_W-1:0] data;
		logic                   kchar;
	} lane_rx_t;

	// Per-lane status as seen by the host
	typedef struct packed {
		logic                  overflow;
		logic [`WFD_CNT_W-1:0] count;
	} lane_stat_t;

	////////////////////
	// Host side

	// Request fields, stable while req is high
	typedef struct packed {
		logic [`WFD_ADDR_W-1:0] addr;
		logic                   we;
		logic [`WFD_DATA_W-1:0] wdata;
	} reg_req_t;

	// Register class after address decode
	typedef enum logic [2:0] {
		SEL_VERSION,
		SEL_CSR,
		SEL_STAT,
		SEL_DATA,
		SEL_NONE
	} reg_sel_e;

	// Four-phase handshake states
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_ACCESS,
		HS_ACK
	} hs_state_e;

endpackage

/* include/wfd_cfg.svh */
`ifndef WFD_CFG_SVH
`define WFD_CFG_SVH

// Link lanes and lane data path
`define WFD_LANES 4
`define WFD_LANE_W 16
`define WFD_FIFO_AW 4
`define WFD_CNT_W 16

// Front-panel LED on-time, in CLK125 cycles
`define WFD_LED_HOLD 16

// Host register port
`define WFD_VERSION 32'h0125_0102
`define WFD_ADDR_W 4
`define WFD_DATA_W 32
`define WFD_CSR_PEER_BIT 31
`define WFD_STAT_OVF_BIT 31

// Word addresses, sized to WFD_ADDR_W
`define WFD_REG_VERSION 4'd0
`define WFD_REG_CSR 4'd1
`define WFD_REG_STAT0 4'd2
`define WFD_REG_DATA0 4'd6
`define WFD_REG_LAST 4'd9

`endif

/* run.sh */
#!/bin/sh
# Build and run the wfd_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module wfd_tb -Mdir "$OBJ" -o wfd_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$OBJ/wfd_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0

/* src.f */
+incdir+include
hw/wfd_pkg.sv
hw/lane_fifo.sv
hw/led_stretch.sv
hw/reg_slave.sv
hw/wfd_main.sv
verif/wfd_tb.sv

/* verif/wfd_tb.sv */
`timescale 1ns/1ps
`include "wfd_cfg.svh"

module wfd_tb import wfd_pkg::*; ();

	localparam int LANES = `WFD_LANES;
	localparam int DEPTH = 1 << `WFD_FIFO_AW;
	localparam int STAT0 = `WFD_REG_STAT0;
	localparam int DATA0 = `WFD_REG_DATA0;
	localparam int HS_TIMEOUT = 50;

	logic CLK125 = 1'b0;
	logic arst_n_i;
	lane_rx_t [LANES-1:0] lane_rx;
	logic req;
	reg_req_t bus_req;
	logic ack;
	logic [`WFD_DATA_W-1:0] rdata;
	logic [LANES-1:0] led;
	logic peer_rst;

	// Reference model state
	logic [`WFD_LANE_W-1:0] lane_q [LANES][$];
	logic [LANES-1:0] model_ovf;
	logic [`WFD_DATA_W-1:0] model_csr;

	int err_cnt;
	int check_cnt;
	int timeout_cnt;
	int test_err_base;
	logic ack_seen;
	logic [`WFD_DATA_W-1:0] exp_data;
	int unsigned seed_val;

	always #2 CLK125 = ~CLK125;

	wfd_main i_wfd_main (
		.CLK125     (CLK125),
		.arst_n_i   (arst_n_i),
		.lane_rx_i  (lane_rx),
		.req_i      (req),
		.bus_req_i  (bus_req),
		.ack_o      (ack),
		.rdata_o    (rdata),
		.led_o      (led),
		.peer_rst_o (peer_rst)
	);

	////////////////////
	// Reference model

	function automatic void model_push(input int lane, input logic [`WFD_LANE_W-1:0] d);
		if (lane_q[lane].size() < DEPTH) begin
			lane_q[lane].push_back(d);
		end else begin
			model_ovf[lane] = 1'b1;
		end
	endfunction

	function automatic logic [`WFD_DATA_W-1:0] ref_read(input logic [`WFD_ADDR_W-1:0] addr);
		logic [`WFD_DATA_W-1:0] r;
		int a;
		r = '0;
		a = int'(addr);
		if (a == 0) begin
			r = `WFD_VERSION;
		end else if (a == 1) begin
			r = model_csr;
		end else if (a >= STAT0 && a < STAT0 + LANES) begin
			r[`WFD_STAT_OVF_BIT] = model_ovf[a - STAT0];
			r[`WFD_CNT_W-1:0] = `WFD_CNT_W'(lane_q[a - STAT0].size());
		end else if (a >= DATA0 && a < DATA0 + LANES) begin
			// Empty lane reads zero and nothing is popped
			if (lane_q[a - DATA0].size() != 0) begin
				r[`WFD_LANE_W-1:0] = lane_q[a - DATA0].pop_front();
			end
		end
		return r;
	endfunction

	function automatic void ref_write(input logic [`WFD_ADDR_W-1:0] addr,
			input logic [`WFD_DATA_W-1:0] wdata);
		int a;
		a = int'(addr);
		if (a == 1) begin
			model_csr = wdata;
		end else if (a >= STAT0 && a < STAT0 + LANES) begin
			model_ovf[a - STAT0] = 1'b0;
		end
	endfunction

	// Every acknowledged access updates the model, reads are compared
	always @(posedge CLK125) begin
		if (ack === 1'b1 && ack_seen !== 1'b1) begin
			if (bus_req.we) begin
				ref_write(bus_req.addr, bus_req.wdata);
			end else begin
				exp_data = ref_read(bus_req.addr);
				check_cnt++;
				assert (rdata === exp_data) else begin
					err_cnt++;
					$display("error at %0t: rdata_o = %h, expected %h (addr %0d)",
						$time, rdata, exp_data, bus_req.addr);
				end
			end
		end
		ack_seen = ack;
	end

	////////////////////
	// Helpers

	task automatic compare_signal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_cnt++;
		assert (got === exp) else begin
			err_cnt++;
			$display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic wait_ack(input logic level, input string what, output logic ok);
		int n;
		n = 0;
		while (ack !== level && n < HS_TIMEOUT) begin
			@(posedge CLK125);
			n++;
		end
		ok = (ack === level);
		if (!ok) begin
			timeout_cnt++;
			err_cnt++;
			$display("timeout at %0t: ack_o never went %0d while %s", $time, level, what);
		end
	endtask

	task automatic host_access(input logic [`WFD_ADDR_W-1:0] addr, input logic we,
			input logic [`WFD_DATA_W-1:0] wdata);
		logic ok;
		@(posedge CLK125);
		wait_ack(1'b0, "waiting to start a request", ok);
		if (ok) begin
			bus_req <= {addr, we, wdata};
			req <= 1'b1;
			@(posedge CLK125);
			wait_ack(1'b1, "waiting for the acknowledge", ok);
			req <= 1'b0;
			if (ok) begin
				@(posedge CLK125);
				wait_ack(1'b0, "waiting for the release", ok);
			end
		end
	endtask

	// Random words on every lane, K flag set with the given chance
	task automatic drive_lanes(input int cycles, input int k_pct);
		logic [`WFD_LANE_W-1:0] d;
		logic k;
		for (int c = 0; c < cycles; c++) begin
			@(posedge CLK125);
			for (int i = 0; i < LANES; i++) begin
				d = `WFD_LANE_W'($urandom);
				k = int'($urandom % 100) < k_pct;
				lane_rx[i] <= '{data: d, kchar: k};
				if (model_csr[i] && !k) begin
					model_push(i, d);
				end
			end
		end
		@(posedge CLK125);
		for (int i = 0; i < LANES; i++) begin
			lane_rx[i].kchar <= 1'b1;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %-24s %s (%0d errors)", name,
			(err_cnt == test_err_base) ? "ok" : "FAILED", err_cnt - test_err_base);
		test_err_base = err_cnt;
	endtask

	////////////////////
	// Test sequence

	initial begin
		int words;
		seed_val = $urandom(32'hdd2b);
		arst_n_i = 1'b0;
		req = 1'b0;
		bus_req = '0;
		for (int i = 0; i < LANES; i++) begin
			lane_rx[i] = '{data: '0, kchar: 1'b1};
		end
		model_ovf = '0;
		model_csr = '0;
		err_cnt = 0;
		check_cnt = 0;
		timeout_cnt = 0;
		test_err_base = 0;
		ack_seen = 1'b0;
		repeat (3) @(posedge CLK125);
		arst_n_i <= 1'b1;
		@(posedge CLK125);

		// Reset state
		compare_signal("ack_o", 32'(ack), 32'h0);
		compare_signal("led_o", 32'(led), 32'h0);
		compare_signal("peer_rst_o", 32'(peer_rst), 32'h0);
		host_access(`WFD_REG_CSR, 1'b0, '0);
		for (int i = 0; i < LANES; i++) begin
			host_access(`WFD_ADDR_W'(STAT0 + i), 1'b0, '0);
		end
		report_test("reset");

		// Version and control register
		host_access(`WFD_REG_VERSION, 1'b0, '0);
		host_access(`WFD_REG_CSR, 1'b1, 32'h8000_0005);
		host_access(`WFD_REG_CSR, 1'b0, '0);
		compare_signal("peer_rst_o", 32'(peer_rst), 32'h1);
		host_access(`WFD_REG_CSR, 1'b1, 32'h0);
		host_access(`WFD_REG_CSR, 1'b0, '0);
		compare_signal("peer_rst_o", 32'(peer_rst), 32'h0);
		report_test("version_csr");

		// Disabled lanes first, then all lanes on
		drive_lanes(12, 25);
		for (int i = 0; i < LANES; i++) begin
			host_access(`WFD_ADDR_W'(STAT0 + i), 1'b0, '0);
		end
		host_access(`WFD_REG_CSR, 1'b1, 32'hf);
		drive_lanes(10, 25);
		for (int i = 0; i < LANES; i++) begin
			host_access(`WFD_ADDR_W'(STAT0 + i), 1'b0, '0);
		end
		report_test("lane_accept");

		// Drain each lane, status after every pop
		for (int i = 0; i < LANES; i++) begin
			words = lane_q[i].size();
			for (int j = 0; j < words; j++) begin
				host_access(`WFD_ADDR_W'(DATA0 + i), 1'b0, '0);
				host_access(`WFD_ADDR_W'(STAT0 + i), 1'b0, '0);
			end
			host_access(`WFD_ADDR_W'(DATA0 + i), 1'b0, '0);
		end
		report_test("data_read");

		// Overflow on lane 2 only
		host_access(`WFD_REG_CSR, 1'b1, 32'h4);
		drive_lanes(DEPTH + 4, 0);
		@(posedge CLK125);
		compare_signal("led_o", 32'(led), 32'h4);
		host_access(`WFD_ADDR_W'(STAT0 + 2), 1'b0, '0);
		host_access(`WFD_ADDR_W'(STAT0 + 2), 1'b1, '0);
		host_access(`WFD_ADDR_W'(STAT0 + 2), 1'b0, '0);
		for (int j = 0; j <= DEPTH; j++) begin
			host_access(`WFD_ADDR_W'(DATA0 + 2), 1'b0, '0);
		end
		repeat (`WFD_LED_HOLD + 4) @(posedge CLK125);
		compare_signal("led_o", 32'(led), 32'h0);
		report_test("overflow_led");

		$display("checks %0d, errors %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
		if (err_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
